/* bench/core_region_tests.txt */
// kind addr data be expected, all hex
// kind 1 lsu wr, 2 lsu rd, 3 slave wr, 4 slave rd, 5 slave rd + two lsu rd, 6 drain, 0 end
1 00100010 11223344 f 00000000
1 00100010 aabbccdd 5 00000000
2 00100010 00000000 0 11bb33dd
6 00000000 00000000 0 00000000
1 20000040 cafef00d f 00000000
1 20000040 00990000 4 00000000
2 20000040 00000000 0 ca99f00d
2 30000080 00000000 0 00000000
6 00000000 00000000 0 00000000
3 00100100 5a5a0001 f 00000000
2 00100100 00000000 0 5a5a0001
1 00100104 0badbeef f 00000000
6 00000000 00000000 0 00000000
4 00100104 00000000 0 0badbeef
3 00100104 00000077 1 00000000
2 00100104 00000000 0 0badbe77
6 00000000 00000000 0 00000000
5 00100100 00000000 0 5a5a0001
6 00000000 00000000 0 00000000
1 00200010 12345678 3 00000000
2 20000040 00000000 0 ca99f00d
2 00100010 00000000 0 11bb33dd
2 00200010 00000000 0 00005678
2 00100100 00000000 0 5a5a0001
2 00100104 00000000 0 0badbe77
2 00100010 00000000 0 11bb33dd
6 00000000 00000000 0 00000000
0 00000000 00000000 0 00000000

/* src.f */
rtl/core_region_pkg.sv
rtl/sp_ram.sv
rtl/ram_mux.sv
rtl/lsu_demux.sv
rtl/ext_bus_bridge.sv
rtl/mem_slave_port.sv
rtl/core_region_top.sv
bench/tb_checker.sv
bench/tb_core_region.sv

/* Bender.yml */
package:
  name: core_region

sources:
  - rtl/core_region_pkg.sv
  - rtl/sp_ram.sv
  - rtl/ram_mux.sv
  - rtl/lsu_demux.sv
  - rtl/ext_bus_bridge.sv
  - rtl/mem_slave_port.sv
  - rtl/core_region_top.sv
  - target: test
    files:
      - bench/tb_checker.sv
      - bench/tb_core_region.sv

/* bench/tb_core_region.sv */
/* core region testbench
   runs the operations of the test file and answers the external bus */
`timescale 1ns/100ps

module tb_core_region
  import core_region_pkg::*;
();

  localparam int TEST_LINES = 64;
  localparam int WAIT_LIMIT = 100;

  logic  clk = 1'b0;
  logic  rst_n;

  logic  lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  addr_t lsu_addr_i;
  be_t   lsu_be_i;
  data_t lsu_wdata_i, lsu_rdata_o;

  logic  ext_req_o, ext_we_o, ext_ack_i;
  addr_t ext_addr_o;
  be_t   ext_be_o;
  data_t ext_wdata_o, ext_rdata_i;

  logic  slv_req_i, slv_we_i, slv_ack_o;
  addr_t slv_addr_i;
  be_t   slv_be_i;
  data_t slv_wdata_i, slv_rdata_o;

  // five words per line: kind, addr, data, be, expected read word
  data_t       test_words [5*TEST_LINES];
  data_t       ext_mem [256];
  logic [15:0] lfsr_q = 16'd77;
  int          aborts = 0;

  always #4 clk = ~clk;

  core_region_top core_region_top_i (.*);

  tb_checker check_i (
    .clk, .rst_n,
    .lsu_gnt_i (lsu_gnt_o), .lsu_addr_i, .lsu_rvalid_i (lsu_rvalid_o),
    .lsu_rdata_i (lsu_rdata_o),
    .ext_req_i (ext_req_o), .ext_addr_i (ext_addr_o), .ext_we_i (ext_we_o),
    .ext_be_i (ext_be_o), .ext_wdata_i (ext_wdata_o),
    .slv_ack_i (slv_ack_o), .slv_rdata_i (slv_rdata_o)
  );

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | lfsr_q[0];
      lfsr_q = next_lfsr(lfsr_q);
    end
  endtask

  task automatic finish_run();
    int open;
    open = check_i.open_items();
    if (open != 0) begin
      $display("%0d expected transfers never completed", open);
    end
    $display("errors: data %0d, protocol %0d, aborted %0d, missing %0d",
             check_i.data_errors, check_i.proto_errors, aborts, open);
    if (check_i.data_errors == 0 && check_i.proto_errors == 0 && aborts == 0 && open == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic abort_run(input string why);
    $display("run aborted: %s", why);
    aborts++;
    finish_run();
  endtask

  task automatic lsu_access(input logic we, input addr_t addr, input data_t wdata,
                            input be_t be, input data_t exp_word);
    int waited;
    waited = 0;
    check_i.lsu_expect(we, exp_word);
    if (addr[ADDR_W-1 -: LOCAL_PREFIX_W] != LOCAL_PREFIX) begin
      check_i.ext_expect(addr, we, be, wdata);
    end
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    @(posedge clk);
    while (!lsu_gnt_o) begin
      if (waited == WAIT_LIMIT) abort_run("the lsu request was never granted");
      waited++;
      @(posedge clk);
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
  endtask

  task automatic wait_slave_ack(input logic level);
    int waited;
    waited = 0;
    @(posedge clk);
    while (slv_ack_o !== level) begin
      if (waited == WAIT_LIMIT) abort_run("slv_ack_o never reached its next phase");
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic slave_access(input logic we, input addr_t addr, input data_t wdata,
                              input be_t be, input data_t exp_word);
    check_i.slave_expect(we, exp_word);
    slv_req_i   = 1'b1;
    slv_addr_i  = addr;
    slv_we_i    = we;
    slv_be_i    = be;
    slv_wdata_i = wdata;
    wait_slave_ack(1'b1);
    @(negedge clk);
    slv_req_i = 1'b0;
    wait_slave_ack(1'b0);
    @(negedge clk);
  endtask

  task automatic wait_lsu_idle();
    int waited;
    waited = 0;
    while (check_i.lsu_pending() != 0) begin
      if (waited == WAIT_LIMIT) abort_run("lsu responses stopped arriving");
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic run_op(input data_t kind, input addr_t addr, input data_t wdata,
                        input data_t be, input data_t exp_word);
    case (kind)
      1: lsu_access(1'b1, addr, wdata, be[BE_W-1:0], exp_word);
      2: lsu_access(1'b0, addr, wdata, be[BE_W-1:0], exp_word);
      3: slave_access(1'b1, addr, wdata, be[BE_W-1:0], exp_word);
      4: slave_access(1'b0, addr, wdata, be[BE_W-1:0], exp_word);
      // slave read racing two lsu reads of the same word
      5: fork
        slave_access(1'b0, addr, wdata, be[BE_W-1:0], exp_word);
        begin
          lsu_access(1'b0, addr, wdata, be[BE_W-1:0], exp_word);
          lsu_access(1'b0, addr, wdata, be[BE_W-1:0], exp_word);
        end
      join
      6: wait_lsu_idle();
      default: abort_run("the test file holds an unknown operation kind");
    endcase
  endtask

  initial begin : stimulus
    int line;
    rst_n       = 1'b0;
    lsu_req_i   = 1'b0;
    lsu_addr_i  = '0;
    lsu_we_i    = 1'b0;
    lsu_be_i    = '0;
    lsu_wdata_i = '0;
    ext_ack_i   = 1'b0;
    ext_rdata_i = '0;
    slv_req_i   = 1'b0;
    slv_addr_i  = '0;
    slv_we_i    = 1'b0;
    slv_be_i    = '0;
    slv_wdata_i = '0;
    for (int i = 0; i < 5*TEST_LINES; i++) begin
      test_words[i] = '0;
    end
    $readmemh("bench/core_region_tests.txt", test_words);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    line = 0;
    // a zero kind ends the list
    while (line < TEST_LINES && test_words[5*line] != '0) begin
      run_op(test_words[5*line], test_words[5*line+1], test_words[5*line+2],
             test_words[5*line+3], test_words[5*line+4]);
      line++;
    end
    wait_lsu_idle();
    finish_run();
  end

  // external bus slave with a random answer delay of 0 to 3 cycles
  initial begin : ext_responder
    int delay;
    int waited;
    int idx;
    for (int i = 0; i < 256; i++) begin
      ext_mem[i] = '0;
    end
    forever begin
      @(negedge clk);
      if (ext_req_o === 1'b1) begin
        take_bits(2, delay);
        repeat (delay) @(negedge clk);
        idx = ext_addr_o[9:2];
        if (ext_we_o) begin
          for (int b = 0; b < BE_W; b++) begin
            if (ext_be_o[b]) begin
              ext_mem[idx][8*b +: 8] = ext_wdata_o[8*b +: 8];
            end
          end
        end
        ext_rdata_i = ext_mem[idx];
        ext_ack_i   = 1'b1;
        waited = 0;
        while (ext_req_o) begin
          if (waited == WAIT_LIMIT) abort_run("ext_req_o stayed high after the ack");
          waited++;
          @(negedge clk);
        end
        ext_ack_i = 1'b0;
      end
    end
  end

endmodule

/* bench/tb_checker.sv */
/* response checker
   compares lsu responses, external bus transfers and slave reads with queued expectations */
`timescale 1ns/100ps

module tb_checker
  import core_region_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  lsu_gnt_i,
  input  addr_t lsu_addr_i,
  input  logic  lsu_rvalid_i,
  input  data_t lsu_rdata_i,
  input  logic  ext_req_i,
  input  addr_t ext_addr_i,
  input  logic  ext_we_i,
  input  be_t   ext_be_i,
  input  data_t ext_wdata_i,
  input  logic  slv_ack_i,
  input  data_t slv_rdata_i
);

  int data_errors = 0;
  int proto_errors = 0;

  // {we, expected read word}
  logic [DATA_W:0] lsu_exp_q [$];
  logic [DATA_W:0] slv_exp_q [$];
  // {addr, we, be, wdata}
  logic [ADDR_W+BE_W+DATA_W:0] ext_exp_q [$];
  // grant cycle and target of each granted lsu request
  int   gnt_cycle_q [$];
  logic gnt_local_q [$];

  int   cycle = 0;
  int   gnt_cycle;
  logic gnt_local;
  logic is_local;
  logic ext_req_q;
  logic slv_ack_q;
  logic ram_gnt_q;
  logic [DATA_W:0] exp_rd;
  // expectation of the slave transfer whose ack is up
  logic [DATA_W:0] slv_cur;
  logic [ADDR_W+BE_W+DATA_W:0] exp_ext;

  task automatic lsu_expect(input logic we, input data_t rdata);
    lsu_exp_q.push_back({we, rdata});
  endtask

  task automatic slave_expect(input logic we, input data_t rdata);
    slv_exp_q.push_back({we, rdata});
  endtask

  task automatic ext_expect(input addr_t addr, input logic we, input be_t be,
                            input data_t wdata);
    ext_exp_q.push_back({addr, we, be, wdata});
  endtask

  function automatic int lsu_pending();
    return lsu_exp_q.size();
  endfunction

  function automatic int open_items();
    return lsu_exp_q.size() + ext_exp_q.size() + slv_exp_q.size();
  endfunction

  task automatic compare_word(input string name, input data_t got, input data_t exp_word);
    if (got !== exp_word) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp_word);
      data_errors++;
    end
  endtask

  assign is_local = (lsu_addr_i[ADDR_W-1 -: LOCAL_PREFIX_W] == LOCAL_PREFIX);

  always @(posedge clk) begin
    if (!rst_n) begin
      ext_req_q = 1'b0;
      slv_ack_q = 1'b0;
      ram_gnt_q = 1'b0;
      slv_cur   = {1'b1, {DATA_W{1'b0}}};
    end else begin
      cycle++;
      // responses first, a grant in this cycle cannot be answered yet
      if (lsu_rvalid_i) begin
        if (lsu_exp_q.size() == 0 || gnt_cycle_q.size() == 0) begin
          $display("lsu_rvalid_o came without a granted request at %0t", $time);
          proto_errors++;
        end else begin
          exp_rd    = lsu_exp_q.pop_front();
          gnt_cycle = gnt_cycle_q.pop_front();
          gnt_local = gnt_local_q.pop_front();
          if (gnt_local && gnt_cycle != cycle - 1) begin
            $display("local response came %0d cycles after its grant", cycle - gnt_cycle);
            proto_errors++;
          end
          if (!exp_rd[DATA_W]) begin
            compare_word("lsu_rdata_o", lsu_rdata_i, exp_rd[DATA_W-1:0]);
          end
        end
      end
      if (lsu_gnt_i) begin
        gnt_cycle_q.push_back(cycle);
        gnt_local_q.push_back(is_local);
      end

      // ack rises one cycle after the slave's RAM access
      if (slv_ack_i && !slv_ack_q) begin
        if (ram_gnt_q) begin
          $display("lsu was granted the RAM in a slave access cycle at %0t", $time);
          proto_errors++;
        end
        if (slv_exp_q.size() == 0) begin
          $display("slv_ack_o rose with no slave transfer pending");
          proto_errors++;
          slv_cur = {1'b1, {DATA_W{1'b0}}};
        end else begin
          slv_cur = slv_exp_q.pop_front();
        end
      end
      // read word must hold for every cycle of the ack phase
      if (slv_ack_i && !slv_cur[DATA_W]) begin
        compare_word("slv_rdata_o", slv_rdata_i, slv_cur[DATA_W-1:0]);
      end

      if (ext_req_i && !ext_req_q) begin
        if (ext_exp_q.size() == 0) begin
          $display("ext_req_o rose for an access that was not external");
          proto_errors++;
        end else begin
          exp_ext = ext_exp_q.pop_front();
          compare_word("ext_addr_o", ext_addr_i, exp_ext[DATA_W+BE_W+1 +: ADDR_W]);
          compare_word("ext_we_o", data_t'(ext_we_i), data_t'(exp_ext[DATA_W+BE_W]));
          compare_word("ext_be_o", data_t'(ext_be_i), data_t'(exp_ext[DATA_W +: BE_W]));
          compare_word("ext_wdata_o", ext_wdata_i, exp_ext[DATA_W-1:0]);
        end
      end

      ext_req_q = ext_req_i;
      slv_ack_q = slv_ack_i;
      ram_gnt_q = lsu_gnt_i && is_local;
    end
  end

endmodule

/* rtl/core_region_top.sv */
/* core region memory side
   lsu demux, external bus bridge, slave port and the arbitrated data RAM */
`timescale 1ns/100ps

module core_region_top
  import core_region_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  lsu_req_i,
  input  addr_t lsu_addr_i,
  input  logic  lsu_we_i,
  input  be_t   lsu_be_i,
  input  data_t lsu_wdata_i,
  output logic  lsu_gnt_o,
  output logic  lsu_rvalid_o,
  output data_t lsu_rdata_o,

  output logic  ext_req_o,
  output addr_t ext_addr_o,
  output logic  ext_we_o,
  output be_t   ext_be_o,
  output data_t ext_wdata_o,
  input  logic  ext_ack_i,
  input  data_t ext_rdata_i,

  input  logic  slv_req_i,
  input  addr_t slv_addr_i,
  input  logic  slv_we_i,
  input  be_t   slv_be_i,
  input  data_t slv_wdata_i,
  output logic  slv_ack_o,
  output data_t slv_rdata_o
);

  // demux to ram arbiter
  logic      ram_req, ram_gnt, ram_rvalid;
  data_t     ram_rdata;
  // demux to bridge
  logic      brg_req, brg_gnt, brg_rvalid;
  data_t     brg_rdata;
  // slave port to ram arbiter
  logic      slv_mem_req, slv_mem_we;
  addr_t     slv_mem_addr;
  be_t       slv_mem_be;
  data_t     slv_mem_wdata, slv_mem_rdata;
  // arbiter to sram
  logic      sram_en, sram_we;
  ram_addr_t sram_addr;
  be_t       sram_be;
  data_t     sram_wdata, sram_rdata;

  lsu_demux lsu_demux_i (
    .clk, .rst_n,
    .lsu_req_i, .lsu_addr_i, .lsu_we_i, .lsu_be_i, .lsu_wdata_i,
    .lsu_gnt_o, .lsu_rvalid_o, .lsu_rdata_o,
    .ram_req_o (ram_req), .ram_gnt_i (ram_gnt),
    .ram_rvalid_i (ram_rvalid), .ram_rdata_i (ram_rdata),
    .ext_req_o (brg_req), .ext_gnt_i (brg_gnt),
    .ext_rvalid_i (brg_rvalid), .ext_rdata_i (brg_rdata)
  );

  ext_bus_bridge ext_bus_bridge_i (
    .clk, .rst_n,
    .req_i (brg_req), .addr_i (lsu_addr_i), .we_i (lsu_we_i),
    .be_i (lsu_be_i), .wdata_i (lsu_wdata_i),
    .gnt_o (brg_gnt), .rvalid_o (brg_rvalid), .rdata_o (brg_rdata),
    .ext_req_o, .ext_addr_o, .ext_we_o, .ext_be_o, .ext_wdata_o,
    .ext_ack_i, .ext_rdata_i
  );

  mem_slave_port mem_slave_port_i (
    .clk, .rst_n,
    .slv_req_i, .slv_addr_i, .slv_we_i, .slv_be_i, .slv_wdata_i,
    .slv_ack_o, .slv_rdata_o,
    .mem_req_o (slv_mem_req), .mem_addr_o (slv_mem_addr), .mem_we_o (slv_mem_we),
    .mem_be_o (slv_mem_be), .mem_wdata_o (slv_mem_wdata), .mem_rdata_i (slv_mem_rdata)
  );

  ram_mux ram_mux_i (
    .clk, .rst_n,
    .p0_req_i (slv_mem_req), .p0_addr_i (slv_mem_addr), .p0_we_i (slv_mem_we),
    .p0_be_i (slv_mem_be), .p0_wdata_i (slv_mem_wdata), .p0_rdata_o (slv_mem_rdata),
    .p1_req_i (ram_req), .p1_addr_i (lsu_addr_i), .p1_we_i (lsu_we_i),
    .p1_be_i (lsu_be_i), .p1_wdata_i (lsu_wdata_i),
    .p1_gnt_o (ram_gnt), .p1_rvalid_o (ram_rvalid), .p1_rdata_o (ram_rdata),
    .ram_en_o (sram_en), .ram_addr_o (sram_addr), .ram_we_o (sram_we),
    .ram_be_o (sram_be), .ram_wdata_o (sram_wdata), .ram_rdata_i (sram_rdata)
  );

  sp_ram data_ram_i (
    .clk,
    .en_i (sram_en), .addr_i (sram_addr), .we_i (sram_we),
    .be_i (sram_be), .wdata_i (sram_wdata), .rdata_o (sram_rdata)
  );

endmodule

/* rtl/mem_slave_port.sv */
/* slave port into the data RAM
   one single-cycle RAM access per four-phase req/ack transfer */
`timescale 1ns/100ps

module mem_slave_port
  import core_region_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  slv_req_i,
  input  addr_t slv_addr_i,
  input  logic  slv_we_i,
  input  be_t   slv_be_i,
  input  data_t slv_wdata_i,
  output logic  slv_ack_o,
  output data_t slv_rdata_o,

  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_we_o,
  output be_t   mem_be_o,
  output data_t mem_wdata_o,
  input  data_t mem_rdata_i
);

  typedef enum logic [1:0] {IDLE, ACCESS, CAPTURE, HOLD} state_e;

  state_e state_q;
  data_t  rdata_q;

  // access fields taken straight from the held slave request
  assign mem_req_o   = (state_q == ACCESS);
  assign mem_addr_o  = slv_addr_i;
  assign mem_we_o    = slv_we_i;
  assign mem_be_o    = slv_be_i;
  assign mem_wdata_o = slv_wdata_i;

  assign slv_ack_o   = (state_q == CAPTURE) || (state_q == HOLD);
  // first ack cycle sees the RAM output directly
  assign slv_rdata_o = (state_q == CAPTURE) ? mem_rdata_i : rdata_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (slv_req_i) state_q <= ACCESS;
        ACCESS:  state_q <= CAPTURE;
        CAPTURE: state_q <= slv_req_i ? HOLD : IDLE;
        HOLD:    if (!slv_req_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == CAPTURE) begin
      rdata_q <= mem_rdata_i;
    end
  end

  slv_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    slv_req_i && !slv_ack_o |=> slv_req_i);

endmodule

/* rtl/ext_bus_bridge.sv */
/* external bus bridge
   turns granted lsu accesses into four-phase req/ack transfers */
`timescale 1ns/100ps

module ext_bus_bridge
  import core_region_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  req_i,
  input  addr_t addr_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output data_t rdata_o,

  output logic  ext_req_o,
  output addr_t ext_addr_o,
  output logic  ext_we_o,
  output be_t   ext_be_o,
  output data_t ext_wdata_o,
  input  logic  ext_ack_i,
  input  data_t ext_rdata_i
);

  typedef enum logic [1:0] {IDLE, REQ, RESP, WAIT_LOW} state_e;

  state_e state_q;

  assign gnt_o     = req_i & (state_q == IDLE);
  assign ext_req_o = (state_q == REQ);
  assign rvalid_o  = (state_q == RESP);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:     if (gnt_o) state_q <= REQ;
        REQ:      if (ext_ack_i) state_q <= RESP;
        // req is already low here, ack may still be up
        RESP:     state_q <= ext_ack_i ? WAIT_LOW : IDLE;
        WAIT_LOW: if (!ext_ack_i) state_q <= IDLE;
        default:  state_q <= IDLE;
      endcase
    end
  end

  // transfer fields and read word
  always_ff @(posedge clk) begin
    if (gnt_o) begin
      ext_addr_o  <= addr_i;
      ext_we_o    <= we_i;
      ext_be_o    <= be_i;
      ext_wdata_o <= wdata_i;
    end
    if (ext_req_o && ext_ack_i) begin
      rdata_o <= ext_rdata_i;
    end
  end

  ext_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_o && $past(ext_req_o) |->
      $stable({ext_addr_o, ext_we_o, ext_be_o, ext_wdata_o}));

endmodule

/* rtl/lsu_demux.sv */
/* lsu address demux
   decodes the local prefix, picks the grant and routes responses back */
`timescale 1ns/100ps

module lsu_demux
  import core_region_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  lsu_req_i,
  input  addr_t lsu_addr_i,
  input  logic  lsu_we_i,
  input  be_t   lsu_be_i,
  input  data_t lsu_wdata_i,
  output logic  lsu_gnt_o,
  output logic  lsu_rvalid_o,
  output data_t lsu_rdata_o,

  output logic  ram_req_o,
  input  logic  ram_gnt_i,
  input  logic  ram_rvalid_i,
  input  data_t ram_rdata_i,

  output logic  ext_req_o,
  input  logic  ext_gnt_i,
  input  logic  ext_rvalid_i,
  input  data_t ext_rdata_i
);

  lsu_target_e req_target;
  lsu_target_e target_q;
  logic [1:0]  pending_q;
  logic        allow;

  assign req_target = (lsu_addr_i[ADDR_W-1 -: LOCAL_PREFIX_W] == LOCAL_PREFIX) ?
                      TARGET_RAM : TARGET_EXT;

  // same target may overlap, a switch waits until all responses are back
  assign allow = (pending_q == 2'd0) ||
                 ((req_target == target_q) && ((pending_q != 2'd2) || lsu_rvalid_o));

  assign ram_req_o = lsu_req_i & allow & (req_target == TARGET_RAM);
  assign ext_req_o = lsu_req_i & allow & (req_target == TARGET_EXT);
  assign lsu_gnt_o = (ram_req_o & ram_gnt_i) | (ext_req_o & ext_gnt_i);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      target_q  <= TARGET_RAM;
      pending_q <= 2'd0;
    end else begin
      if (lsu_gnt_o) begin
        target_q <= req_target;
      end
      pending_q <= pending_q + {1'b0, lsu_gnt_o} - {1'b0, lsu_rvalid_o};
    end
  end

  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (target_q == TARGET_EXT) ? ext_rdata_i : ram_rdata_i;

  rvalid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_rvalid_i && ext_rvalid_i));

  // master keeps its request until granted
  lsu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_req_i && !lsu_gnt_o |=>
      lsu_req_i && $stable({lsu_addr_i, lsu_we_i, lsu_be_i, lsu_wdata_i}));

endmodule

/* rtl/ram_mux.sv */
/* two-port arbiter in front of the data RAM
   port 0 (slave port) always wins, port 1 (lsu) gets what is left */
`timescale 1ns/100ps

module ram_mux
  import core_region_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      p0_req_i,
  input  addr_t     p0_addr_i,
  input  logic      p0_we_i,
  input  be_t       p0_be_i,
  input  data_t     p0_wdata_i,
  output data_t     p0_rdata_o,

  input  logic      p1_req_i,
  input  addr_t     p1_addr_i,
  input  logic      p1_we_i,
  input  be_t       p1_be_i,
  input  data_t     p1_wdata_i,
  output logic      p1_gnt_o,
  output logic      p1_rvalid_o,
  output data_t     p1_rdata_o,

  output logic      ram_en_o,
  output ram_addr_t ram_addr_o,
  output logic      ram_we_o,
  output be_t       ram_be_o,
  output data_t     ram_wdata_o,
  input  data_t     ram_rdata_i
);

  logic rvalid_q;
  // 1 when the last access came from port 1
  logic owner_q;

  assign ram_en_o = p0_req_i | p1_req_i;
  assign p1_gnt_o = p1_req_i & ~p0_req_i;

  always_comb begin
    if (p0_req_i) begin
      ram_addr_o  = p0_addr_i[RAM_AW+1:2];
      ram_we_o    = p0_we_i;
      ram_be_o    = p0_be_i;
      ram_wdata_o = p0_wdata_i;
    end else begin
      ram_addr_o  = p1_addr_i[RAM_AW+1:2];
      ram_we_o    = p1_we_i;
      ram_be_o    = p1_be_i;
      ram_wdata_o = p1_wdata_i;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      owner_q  <= 1'b0;
    end else begin
      rvalid_q <= ram_en_o;
      if (ram_en_o) begin
        owner_q <= ~p0_req_i;
      end
    end
  end

  // read word goes to both, the valid only to the owner
  assign p0_rdata_o  = ram_rdata_i;
  assign p1_rdata_o  = ram_rdata_i;
  assign p1_rvalid_o = rvalid_q & owner_q;

  p1_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    p1_rvalid_o == $past(p1_gnt_o));

endmodule

/* rtl/sp_ram.sv */
/* single-port data RAM
   byte-enabled write, registered read one cycle after enable */
`timescale 1ns/100ps

module sp_ram
  import core_region_pkg::*;
(
  input  logic      clk,
  input  logic      en_i,
  input  ram_addr_t addr_i,
  input  logic      we_i,
  input  be_t       be_i,
  input  data_t     wdata_i,
  output data_t     rdata_o
);

  data_t mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // only enabled byte lanes change
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // read returns the word before a same-cycle write
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* rtl/core_region_pkg.sv */
/* core region package
   bus widths, local region decode and the RAM geometry */
package core_region_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // data RAM geometry
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // top address bits compared against the local prefix
  localparam int                    LOCAL_PREFIX_W = 12;
  localparam logic [LOCAL_PREFIX_W-1:0] LOCAL_PREFIX = 12'h001;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // word address, bus address bits 11..2
  typedef logic [RAM_AW-1:0] ram_addr_t;

  // source of a pending lsu response
  typedef enum logic {
    TARGET_RAM = 1'b0,
    TARGET_EXT = 1'b1
  } lsu_target_e;

endpackage
